// ==== src/bsplit_defs.svh ====
`ifndef BSPLIT_DEFS_SVH
`define BSPLIT_DEFS_SVH

`define ID_W            4
`define ADDR_W          32
`define LEN_W           8   // beats minus one.
`define MAX_PIECE_BEATS 16
`define BEAT_BYTES      4
`define QUEUE_DEPTH     4

`endif

// ==== src/bsplit_pkg.sv ====
`include "bsplit_defs.svh"

package bsplit_pkg;

  typedef struct packed {
    logic [`ID_W-1:0]   id;
    logic [`ADDR_W-1:0] addr;
    logic [`LEN_W-1:0]  len;   // beats minus one.
  } aw_req_t;

  typedef struct packed {
    logic [`ID_W-1:0]  id;
    logic              split;       // more than one piece.
    logic [`LEN_W-1:0] repeat_cnt;  // pieces minus one.
  } b_cmd_t;

  // numeric order is also the severity order.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  typedef enum logic {
    ST_IDLE,
    ST_ISSUE
  } split_state_e;

endpackage

// ==== src/aw_splitter.sv ====
`include "bsplit_defs.svh"

module aw_splitter (
  input  logic                ACLK,
  input  logic                ARESET,
  input  bsplit_pkg::aw_req_t s_aw,
  input  logic                s_aw_valid,
  output logic                s_aw_ready,
  output bsplit_pkg::aw_req_t m_aw,
  output logic                m_aw_valid,
  input  logic                m_aw_ready,
  input  logic                cmd_full,
  output logic                cmd_push,
  output bsplit_pkg::b_cmd_t  cmd_push_data
);
  import bsplit_pkg::*;

  localparam int PIECE_SHIFT = $clog2(`MAX_PIECE_BEATS);
  localparam logic [`LEN_W-1:0] PIECE_LEN = `LEN_W'(`MAX_PIECE_BEATS - 1);
  localparam logic [`LEN_W-1:0] PIECE_BEATS = `LEN_W'(`MAX_PIECE_BEATS);
  localparam logic [`ADDR_W-1:0] PIECE_BYTES = `ADDR_W'(`MAX_PIECE_BEATS * `BEAT_BYTES);

  split_state_e       state;
  logic [`ID_W-1:0]   id_q;
  logic [`ADDR_W-1:0] addr_q;
  logic [`LEN_W-1:0]  rem_q;        // beats still to issue, minus one.
  logic               accept;
  logic               last_piece;
  logic               piece_done;

  assign s_aw_ready = (state == ST_IDLE) && !cmd_full;
  assign accept     = s_aw_valid && s_aw_ready;
  assign m_aw_valid = (state == ST_ISSUE);
  assign last_piece = (rem_q <= PIECE_LEN);
  assign piece_done = m_aw_valid && m_aw_ready;

  // one response command per upstream burst, pushed on acceptance.
  assign cmd_push      = accept;
  assign cmd_push_data = '{
    id:         s_aw.id,
    split:      (s_aw.len > PIECE_LEN),
    repeat_cnt: (s_aw.len >> PIECE_SHIFT)
  };

  assign m_aw = '{
    id:   id_q,
    addr: addr_q,
    len:  (last_piece ? rem_q : PIECE_LEN)
  };

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (piece_done && last_piece) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (accept) begin
      id_q   <= s_aw.id;
      addr_q <= s_aw.addr;
      rem_q  <= s_aw.len;
    end else if (piece_done && !last_piece) begin
      addr_q <= addr_q + PIECE_BYTES;  // next piece starts one full piece later.
      rem_q  <= rem_q - PIECE_BEATS;
    end
  end

endmodule

// ==== src/cmd_queue.sv ====
`include "bsplit_defs.svh"

module cmd_queue (
  input  logic               ACLK,
  input  logic               ARESET,
  input  logic               push,
  input  bsplit_pkg::b_cmd_t push_data,
  output logic               full,
  output bsplit_pkg::b_cmd_t cmd,
  output logic               cmd_valid,
  input  logic               cmd_ready
);
  import bsplit_pkg::*;

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`QUEUE_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`QUEUE_DEPTH);

  b_cmd_t           mem [`QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;

  assign cmd       = mem[rd_ptr];  // head is read without latency.
  assign cmd_valid = (count != '0);

  always_comb begin
    count_next = count;
    if (push && !cmd_ready) begin
      count_next = count + 1'b1;
    end else if (cmd_ready && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b1;  // reads as full while in reset.
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (cmd_ready) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
      full  <= (count_next == FULL_CNT);
    end
  end

  always_ff @(posedge ACLK) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// ==== src/b_merger.sv ====
`include "bsplit_defs.svh"

module b_merger (
  input  logic               ACLK,
  input  logic               ARESET,
  input  bsplit_pkg::b_cmd_t cmd,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  bsplit_pkg::resp_e  m_b_resp,
  input  logic               m_b_valid,
  output logic               m_b_ready,
  output logic [`ID_W-1:0]   s_b_id,
  output bsplit_pkg::resp_e  s_b_resp,
  output logic               s_b_valid,
  input  logic               s_b_ready
);
  import bsplit_pkg::*;

  logic              first_word;   // next response is the first of a burst.
  logic [`LEN_W-1:0] cnt_q;
  logic [`LEN_W-1:0] cnt_pre;
  logic              last_word;
  logic              pop;
  logic              stalled;
  resp_e             acc_q;
  resp_e             resp_sel;

  // the final piece is the only one that has to wait for upstream.
  assign last_word = ((cnt_q == '0) && !first_word) || !cmd.split;
  assign stalled   = last_word && !s_b_ready;
  assign m_b_ready = !stalled;
  assign pop       = m_b_valid && m_b_ready;
  assign cmd_ready = cmd_valid && pop && last_word;

  assign s_b_valid = m_b_valid && last_word;
  assign s_b_id    = cmd.id;
  assign s_b_resp  = resp_sel;

  always_comb begin
    if (!cmd.split) begin
      resp_sel = m_b_resp;  // single piece passes straight through.
    end else if (first_word || (m_b_resp > acc_q)) begin
      resp_sel = m_b_resp;
    end else begin
      resp_sel = acc_q;
    end
  end

  always_ff @(posedge ACLK) begin
    if (pop) begin
      acc_q <= resp_sel;
    end
  end

  assign cnt_pre = first_word ? cmd.repeat_cnt : cnt_q;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      cnt_q      <= '0;
      first_word <= 1'b1;
    end else if (pop) begin
      cnt_q      <= cnt_pre - 1'b1;
      first_word <= last_word;
    end
  end

endmodule

// ==== src/wr_resp_top.sv ====
`include "bsplit_defs.svh"

module wr_resp_top (
  input  logic                ACLK,
  input  logic                ARESET,
  input  bsplit_pkg::aw_req_t s_aw,
  input  logic                s_aw_valid,
  output logic                s_aw_ready,
  output bsplit_pkg::aw_req_t m_aw,
  output logic                m_aw_valid,
  input  logic                m_aw_ready,
  input  bsplit_pkg::resp_e   m_b_resp,
  input  logic                m_b_valid,
  output logic                m_b_ready,
  output logic [`ID_W-1:0]    s_b_id,
  output bsplit_pkg::resp_e   s_b_resp,
  output logic                s_b_valid,
  input  logic                s_b_ready
);
  import bsplit_pkg::*;

  logic   cmd_push;
  b_cmd_t cmd_push_data;
  logic   cmd_full;
  b_cmd_t cmd;
  logic   cmd_valid;
  logic   cmd_ready;

  aw_splitter i_aw_splitter (
    .ACLK          (ACLK),
    .ARESET        (ARESET),
    .s_aw          (s_aw),
    .s_aw_valid    (s_aw_valid),
    .s_aw_ready    (s_aw_ready),
    .m_aw          (m_aw),
    .m_aw_valid    (m_aw_valid),
    .m_aw_ready    (m_aw_ready),
    .cmd_full      (cmd_full),
    .cmd_push      (cmd_push),
    .cmd_push_data (cmd_push_data)
  );

  // response commands in acceptance order.
  cmd_queue i_cmd_queue (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .push      (cmd_push),
    .push_data (cmd_push_data),
    .full      (cmd_full),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready)
  );

  b_merger i_b_merger (
    .ACLK      (ACLK),
    .ARESET    (ARESET),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .m_b_resp  (m_b_resp),
    .m_b_valid (m_b_valid),
    .m_b_ready (m_b_ready),
    .s_b_id    (s_b_id),
    .s_b_resp  (s_b_resp),
    .s_b_valid (s_b_valid),
    .s_b_ready (s_b_ready)
  );

endmodule

// ==== bench/clk_gen.sv ====
module clk_gen (
  output logic ACLK,
  output logic ARESET
);

  initial begin
    ACLK   = 1'b0;
    ARESET = 1'b1;
    repeat (4) @(posedge ACLK);
    #1 ARESET = 1'b0;  // released just after the fourth edge.
  end

  always #2 ACLK = ~ACLK;

endmodule

// ==== bench/wr_resp_assert.sv ====
`include "bsplit_defs.svh"

module wr_resp_assert (
  input logic             ACLK,
  input logic             ARESET,
  input logic             push,
  input logic             full,
  input logic             pop,
  input logic             avail,
  input logic             in_valid,
  input logic             out_valid,
  input logic             out_ready,
  input logic [`ID_W+1:0] out_data
);

  // a downstream response needs a command at the queue head.
  assert property (@(posedge ACLK) disable iff (ARESET) in_valid |-> avail)
    else $error("downstream response arrived with no command queued");

  assert property (@(posedge ACLK) disable iff (ARESET) !(push && full))
    else $error("command pushed into a full queue");

  assert property (@(posedge ACLK) disable iff (ARESET) pop |-> avail)
    else $error("command popped from an empty queue");

  assert property (@(posedge ACLK) disable iff (ARESET)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("upstream response changed before it was taken");

endmodule

bind cmd_queue wr_resp_assert i_queue_assert (
  .ACLK(ACLK), .ARESET(ARESET), .push(push), .full(full), .pop(cmd_ready),
  .avail(cmd_valid), .in_valid(1'b0), .out_valid(1'b0), .out_ready(1'b1),
  .out_data('0)
);

bind b_merger wr_resp_assert i_merger_assert (
  .ACLK(ACLK), .ARESET(ARESET), .push(1'b0), .full(1'b0), .pop(1'b0),
  .avail(cmd_valid), .in_valid(m_b_valid), .out_valid(s_b_valid),
  .out_ready(s_b_ready), .out_data({s_b_id, s_b_resp})
);

// ==== bench/tb_wr_resp.sv ====
`include "bsplit_defs.svh"

module tb_wr_resp;
  import bsplit_pkg::*;

  logic ACLK, ARESET;
  aw_req_t s_aw, m_aw, exp_p;
  logic s_aw_valid, s_aw_ready, m_aw_valid, m_aw_ready;
  resp_e m_b_resp, s_b_resp, merged;
  logic m_b_valid, m_b_ready, s_b_valid, s_b_ready;
  logic [`ID_W-1:0] s_b_id, exp_id;
  aw_req_t exp_aw[$];
  logic [`ID_W-1:0] exp_b_id[$];
  int exp_b_pieces[$];
  resp_e codes[$];
  int errors = 0, checks = 0, b_todo = 0, exp_n;
  logic hold_b = 1'b0, b_fire;
  string cur_test = "reset";

  clk_gen i_clk_gen (.ACLK(ACLK), .ARESET(ARESET));

  wr_resp_top i_wr_resp_top (.*);

  // expected piece idx of a request, following the split rule.
  function automatic aw_req_t expected_piece(aw_req_t req, int idx);
    aw_req_t p;
    int beats;
    beats  = int'(req.len) + 1;
    p.id   = req.id;
    p.addr = req.addr + `ADDR_W'(idx * `MAX_PIECE_BEATS * `BEAT_BYTES);
    if ((idx + 1) * `MAX_PIECE_BEATS < beats) p.len = `LEN_W'(`MAX_PIECE_BEATS - 1);
    else p.len = `LEN_W'(beats - idx * `MAX_PIECE_BEATS - 1);
    return p;
  endfunction

  // worst code wins, by numeric order.
  function automatic resp_e merge_codes(input resp_e list[$]);
    resp_e worst;
    worst = list[0];
    foreach (list[i]) if (list[i] > worst) worst = list[i];
    return worst;
  endfunction

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("Verification passed");
    else $display("Verification failed");
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout in %s: %s", cur_test, what);
    errors++;
    finish_run();
  endtask

  task automatic send_burst(input aw_req_t req);
    int n, pieces;
    logic accepted;
    pieces = (int'(req.len) + `MAX_PIECE_BEATS) / `MAX_PIECE_BEATS;
    for (int i = 0; i < pieces; i++) exp_aw.push_back(expected_piece(req, i));
    exp_b_id.push_back(req.id);
    exp_b_pieces.push_back(pieces);
    @(posedge ACLK);
    #1 s_aw = req;
    s_aw_valid = 1'b1;
    n = 0;
    accepted = 1'b0;
    while (!accepted && n < 400) begin
      @(posedge ACLK);
      accepted = s_aw_ready;
      n++;
    end
    #1 s_aw_valid = 1'b0;
    if (!accepted) timeout_fail("s_aw_ready never came");
  endtask

  task automatic send_random();
    aw_req_t req;
    req.id   = `ID_W'($urandom_range(15));
    req.addr = $urandom & ~32'h3;
    req.len  = `LEN_W'($urandom_range(255));
    send_burst(req);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_b_id.size() != 0 && n < 5000) begin
      @(posedge ACLK);
      n++;
    end
    if (exp_b_id.size() != 0) timeout_fail("upstream responses still missing");
  endtask

  task automatic wait_pieces_issued();
    int n;
    n = 0;
    while (exp_aw.size() != 0 && n < 500) begin
      @(posedge ACLK);
      n++;
    end
    if (exp_aw.size() != 0) timeout_fail("downstream pieces still missing");
  endtask

  // downstream slave and upstream response ready.
  always @(posedge ACLK) begin
    b_fire = !ARESET && m_b_valid && m_b_ready;
    if (!ARESET && m_aw_valid && m_aw_ready) b_todo++;
    if (b_fire) b_todo--;
    #1;
    m_aw_ready = ($urandom_range(3) != 0);
    s_b_ready  = ($urandom_range(3) != 0);
    if (b_fire || !m_b_valid) begin
      if (b_todo > 0 && !hold_b && $urandom_range(1) == 1) begin
        m_b_valid = 1'b1;
        m_b_resp  = resp_e'($urandom_range(3));
      end else begin
        m_b_valid = 1'b0;
      end
    end
  end

  always @(posedge ACLK) begin
    if (!ARESET) begin
      if (m_aw_valid && m_aw_ready) begin
        checks++;
        assert (exp_aw.size() != 0) else begin
          errors++;
          $display("%s: downstream piece issued with no request pending", cur_test);
        end
        if (exp_aw.size() != 0) begin
          exp_p = exp_aw.pop_front();
          assert (m_aw == exp_p) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", cur_test, exp_p, m_aw);
          end
        end
      end
      if (m_b_valid && m_b_ready) codes.push_back(m_b_resp);
      if (s_b_valid && !s_b_ready) begin
        checks++;
        assert (!m_b_ready) else begin
          errors++;
          $display("%s: m_b_ready high while a final response is stalled", cur_test);
        end
      end
      if (s_b_valid && s_b_ready) begin
        checks++;
        if (exp_b_id.size() == 0) begin
          errors++;
          $display("%s: upstream response with no burst outstanding", cur_test);
        end else begin
          exp_id = exp_b_id.pop_front();
          exp_n  = exp_b_pieces.pop_front();
          merged = merge_codes(codes);
          assert (codes.size() == exp_n) else begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", cur_test, exp_n, codes.size());
          end
          assert (s_b_id == exp_id) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", cur_test, exp_id, s_b_id);
          end
          assert (s_b_resp == merged) else begin
            errors++;
            $display("Error %s: expected %h, actual %h", cur_test, merged, s_b_resp);
          end
        end
        codes.delete();
      end
    end
  end

  initial begin
    int n;
    s_aw       = '0;
    s_aw_valid = 1'b0;
    m_aw_ready = 1'b0;
    m_b_resp   = RESP_OKAY;
    m_b_valid  = 1'b0;
    s_b_ready  = 1'b0;
    void'($urandom(58203));
    n = 0;
    while ((ARESET || !s_aw_ready) && n < 50) begin
      @(posedge ACLK);
      n++;
      assert (!s_b_valid && !m_aw_valid) else begin
        errors++;
        $display("reset: valid output high after reset");
      end
    end
    if (ARESET || !s_aw_ready) timeout_fail("s_aw_ready did not rise after reset");

    cur_test = "short";
    send_burst('{id: 4'h1, addr: 32'h1000, len: 8'd0});
    send_burst('{id: 4'h2, addr: 32'h2000, len: 8'd7});
    send_burst('{id: 4'h3, addr: 32'h3000, len: 8'd15});
    wait_drained();

    cur_test = "long";
    send_burst('{id: 4'h4, addr: 32'h4000, len: 8'd40});
    send_burst('{id: 4'h5, addr: 32'h8000, len: 8'd255});
    send_burst('{id: 4'h6, addr: 32'hc000, len: 8'd16});
    wait_drained();

    cur_test = "random";
    repeat (30) send_random();
    wait_drained();

    cur_test = "queue_full";
    hold_b = 1'b1;
    repeat (`QUEUE_DEPTH) send_random();
    wait_pieces_issued();
    repeat (4) begin
      @(posedge ACLK);
      checks++;
      assert (!s_aw_ready) else begin
        errors++;
        $display("queue_full: s_aw_ready high with all commands outstanding");
      end
    end
    hold_b = 1'b0;
    repeat (3) send_random();
    wait_drained();

    finish_run();
  end

endmodule

// ==== sim.f ====
+incdir+src
src/bsplit_pkg.sv
src/aw_splitter.sv
src/cmd_queue.sv
src/b_merger.sv
src/wr_resp_top.sv
bench/clk_gen.sv
bench/wr_resp_assert.sv
bench/tb_wr_resp.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_wr_resp -o tb_wr_resp
./obj_dir/tb_wr_resp > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then
  exit 1
fi
exit 0
